// File: run_sim.sh
#!/usr/bin/env bash
# Build the IXU testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
set -o pipefail

verilator --binary --timing -Wno-fatal --top-module ixu_tb -f sources.f -o ixu_tb_sim \
  && ./obj_dir/ixu_tb_sim | tee sim.log \
  && grep -qx "SIMULATION PASSED" sim.log \
  && { echo "Run result: pass"; exit 0; } \
  || { echo "Run result: fail, see sim.log"; exit 1; }

// File: sources.f
src/ixu_op_pkg.sv
src/ixu_result_pkg.sv
src/ixu_issue_queue.sv
src/ixu_sc_pipe.sv
src/ixu_mc_pipe.sv
src/ixu_wb_arbiter.sv
src/ixu.sv
testbench/ixu_tb.sv

// File: src/ixu.sv
// Integer execution unit top with issue queue, ALU pipe, multiplier pipe and arbiter
`timescale 1ns/1ns

module ixu
  import ixu_op_pkg::*, ixu_result_pkg::*;
#(
  parameter int QUEUE_DEPTH = 8
) (
  input  logic        core_clock_i,
  input  logic        reset_i,
  input  logic        core_flush_i,
  input  logic        issue_valid_i,
  input  ixu_uop_t    issue_uop_i,
  output logic        issue_ready_o,
  output logic        complete_valid_o,
  output ixu_result_t complete_o,
  input  logic        complete_ready_i
);

  // Queue to pipes
  logic        sc_valid;
  ixu_uop_t    sc_uop;
  logic        sc_ready;
  logic        mc_valid;
  ixu_uop_t    mc_uop;
  logic        mc_ready;
  // Pipes to arbiter
  logic        sc_res_valid;
  ixu_result_t sc_res;
  logic        sc_res_ready;
  logic        mc_res_valid;
  ixu_result_t mc_res;
  logic        mc_res_ready;

  ixu_issue_queue #(
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) i_issue_queue (
    .core_clock_i (core_clock_i),
    .reset_i      (reset_i),
    .core_flush_i (core_flush_i),
    .issue_valid_i(issue_valid_i),
    .issue_uop_i  (issue_uop_i),
    .issue_ready_o(issue_ready_o),
    .sc_valid_o   (sc_valid),
    .sc_uop_o     (sc_uop),
    .sc_ready_i   (sc_ready),
    .mc_valid_o   (mc_valid),
    .mc_uop_o     (mc_uop),
    .mc_ready_i   (mc_ready)
  );

  ixu_sc_pipe i_sc_pipe (
    .core_clock_i(core_clock_i),
    .reset_i     (reset_i),
    .core_flush_i(core_flush_i),
    .uop_valid_i (sc_valid),
    .uop_i       (sc_uop),
    .uop_ready_o (sc_ready),
    .res_valid_o (sc_res_valid),
    .res_o       (sc_res),
    .res_ready_i (sc_res_ready)
  );

  ixu_mc_pipe i_mc_pipe (
    .core_clock_i(core_clock_i),
    .reset_i     (reset_i),
    .core_flush_i(core_flush_i),
    .uop_valid_i (mc_valid),
    .uop_i       (mc_uop),
    .uop_ready_o (mc_ready),
    .res_valid_o (mc_res_valid),
    .res_o       (mc_res),
    .res_ready_i (mc_res_ready)
  );

  ixu_wb_arbiter i_wb_arbiter (
    .sc_valid_i      (sc_res_valid),
    .sc_res_i        (sc_res),
    .sc_ready_o      (sc_res_ready),
    .mc_valid_i      (mc_res_valid),
    .mc_res_i        (mc_res),
    .mc_ready_o      (mc_res_ready),
    .complete_valid_o(complete_valid_o),
    .complete_o      (complete_o),
    .complete_ready_i(complete_ready_i)
  );

endmodule

// File: src/ixu_issue_queue.sv
// Collapsing issue queue with oldest-first select for the ALU and multiply pipes
`timescale 1ns/1ns

module ixu_issue_queue
  import ixu_op_pkg::*;
#(
  parameter int QUEUE_DEPTH = 8
) (
  input  logic     core_clock_i,
  input  logic     reset_i,
  input  logic     core_flush_i,
  input  logic     issue_valid_i,
  input  ixu_uop_t issue_uop_i,
  output logic     issue_ready_o,
  output logic     sc_valid_o,
  output ixu_uop_t sc_uop_o,
  input  logic     sc_ready_i,
  output logic     mc_valid_o,
  output ixu_uop_t mc_uop_o,
  input  logic     mc_ready_i
);

  localparam int IDX_W = $clog2(QUEUE_DEPTH);

  // Entry 0 is the oldest, valid entries stay packed at the head
  ixu_uop_t               entries_q [QUEUE_DEPTH];
  ixu_uop_t               entries_d [QUEUE_DEPTH];
  logic [QUEUE_DEPTH-1:0] valid_q;
  logic [QUEUE_DEPTH-1:0] valid_d;
  logic [QUEUE_DEPTH-1:0] keep;
  logic [IDX_W-1:0]       sc_idx;
  logic [IDX_W-1:0]       mc_idx;
  logic                   sc_found;
  logic                   mc_found;
  logic                   sc_fire;
  logic                   mc_fire;
  logic                   issue_fire;

  // Two priority searches, one per class
  always_comb begin
    sc_found = 1'b0;
    mc_found = 1'b0;
    sc_idx   = '0;
    mc_idx   = '0;
    for (int i = 0; i < QUEUE_DEPTH; i++) begin
      if (valid_q[i] && !sc_found && ixu_op_class(entries_q[i].opcode) == CLASS_SC) begin
        sc_found = 1'b1;
        sc_idx   = IDX_W'(i);
      end
      if (valid_q[i] && !mc_found && ixu_op_class(entries_q[i].opcode) == CLASS_MC) begin
        mc_found = 1'b1;
        mc_idx   = IDX_W'(i);
      end
    end
  end

  assign sc_valid_o    = sc_found;
  assign sc_uop_o      = entries_q[sc_idx];
  assign mc_valid_o    = mc_found;
  assign mc_uop_o      = entries_q[mc_idx];
  assign sc_fire       = sc_valid_o && sc_ready_i;
  assign mc_fire       = mc_valid_o && mc_ready_i;
  // Last slot empty means at least one free entry
  assign issue_ready_o = !valid_q[QUEUE_DEPTH-1];
  assign issue_fire    = issue_valid_i && issue_ready_o;

  // Drop dispatched entries, close the gaps, then append the new op
  always_comb begin
    int wr_ptr;
    wr_ptr  = 0;
    valid_d = '0;
    for (int i = 0; i < QUEUE_DEPTH; i++) begin
      keep[i]      = valid_q[i] && !(sc_fire && sc_idx == IDX_W'(i)) &&
                     !(mc_fire && mc_idx == IDX_W'(i));
      entries_d[i] = entries_q[i];
    end
    for (int i = 0; i < QUEUE_DEPTH; i++) begin
      if (keep[i]) begin
        entries_d[wr_ptr] = entries_q[i];
        valid_d[wr_ptr]   = 1'b1;
        wr_ptr++;
      end
    end
    if (issue_fire) begin
      entries_d[wr_ptr] = issue_uop_i;
      valid_d[wr_ptr]   = 1'b1;
    end
  end

  always_ff @(posedge core_clock_i) begin
    if (reset_i || core_flush_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_d;
    end
  end

  always_ff @(posedge core_clock_i) begin
    entries_q <= entries_d;
  end

endmodule

// File: src/ixu_mc_pipe.sv
// Iterative shift-add multiplier pipe with busy FSM and held result
`timescale 1ns/1ns

module ixu_mc_pipe
  import ixu_op_pkg::*, ixu_result_pkg::*;
(
  input  logic        core_clock_i,
  input  logic        reset_i,
  input  logic        core_flush_i,
  input  logic        uop_valid_i,
  input  ixu_uop_t    uop_i,
  output logic        uop_ready_o,
  output logic        res_valid_o,
  output ixu_result_t res_o,
  input  logic        res_ready_i
);

  localparam int STEP_W = $clog2(XLEN);

  typedef enum logic [1:0] {
    MC_IDLE,
    MC_BUSY,
    MC_DONE
  } mc_state_e;

  mc_state_e            state_q;
  logic [STEP_W-1:0]    step_q;
  logic [2*XLEN-1:0]    prod_q;
  logic [XLEN-1:0]      mcand_q;
  logic [XLEN:0]        step_sum;
  ixu_opcode_e          op_q;
  logic [PREG_W-1:0]    dest_q;
  logic [ROB_TAG_W-1:0] tag_q;
  logic                 accept;

  assign uop_ready_o = state_q == MC_IDLE;
  assign accept      = uop_valid_i && uop_ready_o;
  assign res_valid_o = state_q == MC_DONE;

  // Multiplier bits sit in the low half and shift out one per step
  assign step_sum = {1'b0, prod_q[2*XLEN-1:XLEN]} + (prod_q[0] ? {1'b0, mcand_q} : '0);

  always_ff @(posedge core_clock_i) begin
    if (reset_i || core_flush_i) begin
      state_q <= MC_IDLE;
      step_q  <= '0;
    end else begin
      case (state_q)
        MC_IDLE: begin
          if (accept) begin
            state_q <= MC_BUSY;
            step_q  <= '0;
          end
        end
        MC_BUSY: begin
          step_q <= step_q + 1'b1;
          if (step_q == STEP_W'(XLEN - 1)) begin
            state_q <= MC_DONE;
          end
        end
        MC_DONE: begin
          if (res_ready_i) begin
            state_q <= MC_IDLE;
          end
        end
        default: state_q <= MC_IDLE;
      endcase
    end
  end

  always_ff @(posedge core_clock_i) begin
    if (accept) begin
      prod_q  <= {{XLEN{1'b0}}, uop_i.operand_b};
      mcand_q <= uop_i.operand_a;
      op_q    <= uop_i.opcode;
      dest_q  <= uop_i.dest;
      tag_q   <= uop_i.rob_tag;
    end else if (state_q == MC_BUSY) begin
      prod_q <= {step_sum, prod_q[XLEN-1:1]};
    end
  end

  always_comb begin
    res_o.data    = (op_q == OP_MULHU) ? prod_q[2*XLEN-1:XLEN] : prod_q[XLEN-1:0];
    res_o.dest    = dest_q;
    res_o.rob_tag = tag_q;
  end

endmodule

// File: src/ixu_op_pkg.sv
// Datapath widths, opcode enum, operation class and the issued micro-op struct
package ixu_op_pkg;

  localparam int XLEN      = 32;
  localparam int ROB_TAG_W = 5;
  localparam int PREG_W    = 6;

  typedef enum logic [3:0] {
    OP_ADD   = 4'd0,
    OP_SUB   = 4'd1,
    OP_AND   = 4'd2,
    OP_OR    = 4'd3,
    OP_XOR   = 4'd4,
    OP_SLL   = 4'd5,
    OP_SRL   = 4'd6,
    OP_SLT   = 4'd7,
    OP_MUL   = 4'd8,
    OP_MULHU = 4'd9
  } ixu_opcode_e;

  // Pipe that executes an op
  typedef enum logic {
    CLASS_SC = 1'b0,
    CLASS_MC = 1'b1
  } ixu_class_e;

  function automatic ixu_class_e ixu_op_class(input ixu_opcode_e op);
    if (op == OP_MUL || op == OP_MULHU) begin
      return CLASS_MC;
    end
    return CLASS_SC;
  endfunction

  // Renamed op with its operand values already read
  typedef struct packed {
    ixu_opcode_e          opcode;
    logic [XLEN-1:0]      operand_a;
    logic [XLEN-1:0]      operand_b;
    logic [PREG_W-1:0]    dest;
    logic [ROB_TAG_W-1:0] rob_tag;
  } ixu_uop_t;

endpackage

// File: src/ixu_result_pkg.sv
// Result struct shared by the execute pipes, the writeback arbiter and completion
package ixu_result_pkg;

  import ixu_op_pkg::*;

  // One finished op on its way to writeback
  typedef struct packed {
    logic [XLEN-1:0]      data;
    logic [PREG_W-1:0]    dest;
    logic [ROB_TAG_W-1:0] rob_tag;
  } ixu_result_t;

endpackage

// File: src/ixu_sc_pipe.sv
// Single-cycle ALU pipe with a result register that holds under back-pressure
`timescale 1ns/1ns

module ixu_sc_pipe
  import ixu_op_pkg::*, ixu_result_pkg::*;
(
  input  logic        core_clock_i,
  input  logic        reset_i,
  input  logic        core_flush_i,
  input  logic        uop_valid_i,
  input  ixu_uop_t    uop_i,
  output logic        uop_ready_o,
  output logic        res_valid_o,
  output ixu_result_t res_o,
  input  logic        res_ready_i
);

  logic [XLEN-1:0] alu_data;
  logic [4:0]      shamt;
  logic            accept;
  logic            res_valid_q;
  ixu_result_t     res_q;

  assign shamt = uop_i.operand_b[4:0];

  always_comb begin
    case (uop_i.opcode)
      OP_ADD:  alu_data = uop_i.operand_a + uop_i.operand_b;
      OP_SUB:  alu_data = uop_i.operand_a - uop_i.operand_b;
      OP_AND:  alu_data = uop_i.operand_a & uop_i.operand_b;
      OP_OR:   alu_data = uop_i.operand_a | uop_i.operand_b;
      OP_XOR:  alu_data = uop_i.operand_a ^ uop_i.operand_b;
      OP_SLL:  alu_data = uop_i.operand_a << shamt;
      OP_SRL:  alu_data = uop_i.operand_a >> shamt;
      OP_SLT:  alu_data = XLEN'($signed(uop_i.operand_a) < $signed(uop_i.operand_b));
      // Multiplies never reach this pipe
      default: alu_data = '0;
    endcase
  end

  // Room for a new op when the register is empty or drains this cycle
  assign uop_ready_o = !res_valid_q || res_ready_i;
  assign accept      = uop_valid_i && uop_ready_o;

  always_ff @(posedge core_clock_i) begin
    if (reset_i || core_flush_i) begin
      res_valid_q <= 1'b0;
    end else if (accept) begin
      res_valid_q <= 1'b1;
    end else if (res_ready_i) begin
      res_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge core_clock_i) begin
    if (accept) begin
      res_q.data    <= alu_data;
      res_q.dest    <= uop_i.dest;
      res_q.rob_tag <= uop_i.rob_tag;
    end
  end

  assign res_valid_o = res_valid_q;
  assign res_o       = res_q;

endmodule

// File: src/ixu_wb_arbiter.sv
// Writeback arbiter merging the ALU and multiplier results into one completion stream
`timescale 1ns/1ns

module ixu_wb_arbiter
  import ixu_result_pkg::*;
(
  input  logic        sc_valid_i,
  input  ixu_result_t sc_res_i,
  output logic        sc_ready_o,
  input  logic        mc_valid_i,
  input  ixu_result_t mc_res_i,
  output logic        mc_ready_o,
  output logic        complete_valid_o,
  output ixu_result_t complete_o,
  input  logic        complete_ready_i
);

  logic sel_mc;

  // Multiplier wins so its long-latency result frees the pipe early
  assign sel_mc = mc_valid_i;

  assign complete_valid_o = mc_valid_i || sc_valid_i;
  assign complete_o       = sel_mc ? mc_res_i : sc_res_i;

  // Only the selected source sees the completion handshake
  assign mc_ready_o = sel_mc && complete_ready_i;
  assign sc_ready_o = !sel_mc && complete_ready_i;

endmodule

// File: testbench/ixu_tb.sv
// Testbench for the integer execution unit with scoreboard, directed tests and timeout
`timescale 1ns/1ns

module ixu_tb
  import ixu_op_pkg::*, ixu_result_pkg::*;
();

  localparam int NUM_TAGS    = 2 ** ROB_TAG_W;
  localparam int NUM_OPS     = 61;
  localparam int CYCLE_LIMIT = NUM_OPS * 40 + 2000;

  logic        core_clock_i;
  logic        reset_i;
  logic        core_flush_i;
  logic        issue_valid_i;
  ixu_uop_t    issue_uop_i;
  logic        issue_ready_o;
  logic        complete_valid_o;
  ixu_result_t complete_o;
  logic        complete_ready_i;

  // Scoreboard indexed by rob_tag
  logic [XLEN-1:0]      exp_data [NUM_TAGS];
  logic [PREG_W-1:0]    exp_dest [NUM_TAGS];
  logic [NUM_TAGS-1:0]  pending;
  int                   issue_cycle [NUM_TAGS];
  int                   done_cycle [NUM_TAGS];
  logic [ROB_TAG_W-1:0] next_tag;
  int                   cycle_cnt = 0;
  int                   pass_cnt;
  int                   fail_cnt;
  logic                 held_valid = 1'b0;
  ixu_result_t          held_res;

  ixu #(.QUEUE_DEPTH(8)) i_ixu (.*);

  initial begin
    core_clock_i = 1'b0;
    forever #50 core_clock_i = ~core_clock_i;
  end

  always @(posedge core_clock_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // Expected result from the opcode rules
  function automatic logic [XLEN-1:0] expected_data(input ixu_opcode_e op,
                                                    input logic [XLEN-1:0] a,
                                                    input logic [XLEN-1:0] b);
    logic [2*XLEN-1:0] prod;
    prod = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
    case (op)
      OP_ADD:   return a + b;
      OP_SUB:   return a - b;
      OP_AND:   return a & b;
      OP_OR:    return a | b;
      OP_XOR:   return a ^ b;
      OP_SLL:   return a << b[4:0];
      OP_SRL:   return a >> b[4:0];
      OP_SLT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      OP_MUL:   return prod[XLEN-1:0];
      OP_MULHU: return prod[2*XLEN-1:XLEN];
      default:  return '0;
    endcase
  endfunction

  // Completion monitor, samples the values present at the rising edge
  always @(posedge core_clock_i) begin
    logic [ROB_TAG_W-1:0] tag;
    if (held_valid && (!complete_valid_o || complete_o != held_res)) begin
      $display("[ERROR] %0t: completion changed while stalled", $time);
      fail_cnt++;
    end
    if (!reset_i && complete_valid_o && complete_ready_i) begin
      tag = complete_o.rob_tag;
      if (!pending[tag]) begin
        $display("Unexpected completion for tag %0d at time %0t", tag, $time);
        fail_cnt++;
      end else if (complete_o.data !== exp_data[tag] || complete_o.dest !== exp_dest[tag]) begin
        $display("[ERROR] %0t: tag %0d gave data %h dest %0d, expected data %h dest %0d",
                 $time, tag, complete_o.data, complete_o.dest, exp_data[tag], exp_dest[tag]);
        fail_cnt++;
      end else begin
        pass_cnt++;
      end
      pending[tag]    = 1'b0;
      done_cycle[tag] = cycle_cnt;
    end
    held_valid = complete_valid_o && !complete_ready_i && !core_flush_i && !reset_i;
    held_res   = complete_o;
  end

  task automatic make_uop(input ixu_opcode_e op, input logic [XLEN-1:0] a,
                          input logic [XLEN-1:0] b, output ixu_uop_t uop);
    uop.opcode         = op;
    uop.operand_a      = a;
    uop.operand_b      = b;
    uop.dest           = PREG_W'($urandom);
    uop.rob_tag        = next_tag;
    exp_data[next_tag] = expected_data(op, a, b);
    exp_dest[next_tag] = uop.dest;
    pending[next_tag]  = 1'b1;
    next_tag           = next_tag + 1'b1;
  endtask

  task automatic drive_uop(input ixu_uop_t uop);
    logic accepted;
    accepted = 1'b0;
    @(negedge core_clock_i);
    issue_valid_i = 1'b1;
    issue_uop_i   = uop;
    while (!accepted) begin
      @(posedge core_clock_i);
      accepted = issue_ready_o;
    end
    issue_cycle[uop.rob_tag] = cycle_cnt;
    @(negedge core_clock_i);
    issue_valid_i = 1'b0;
  endtask

  task automatic issue_op(input ixu_opcode_e op, input logic [XLEN-1:0] a,
                          input logic [XLEN-1:0] b);
    ixu_uop_t uop;
    make_uop(op, a, b, uop);
    drive_uop(uop);
  endtask

  task automatic wait_done(input int max_cycles);
    int waited;
    waited = 0;
    while (pending != '0 && waited < max_cycles) begin
      @(negedge core_clock_i);
      waited++;
    end
    if (pending != '0) begin
      $display("Missing completion for pending tags %h after %0d cycles", pending, max_cycles);
      fail_cnt++;
      pending = '0;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (fail_cnt == errs_before) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d errors", name, fail_cnt - errs_before);
    end
  endtask

  task automatic check_reset_state();
    int errs;
    errs = fail_cnt;
    @(negedge core_clock_i);
    if (issue_ready_o !== 1'b1 || complete_valid_o !== 1'b0) begin
      $display("[ERROR] %0t: issue_ready_o %b complete_valid_o %b after reset",
               $time, issue_ready_o, complete_valid_o);
      fail_cnt++;
    end else begin
      pass_cnt++;
    end
    report_test("reset state", errs);
  endtask

  task automatic run_alu_ops();
    ixu_opcode_e alu_ops [8];
    int          errs;
    errs    = fail_cnt;
    alu_ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_SLT};
    foreach (alu_ops[i]) begin
      issue_op(alu_ops[i], '0, '0);
      issue_op(alu_ops[i], 32'hffff_ffff, 32'h0000_0001);
      issue_op(alu_ops[i], 32'h8000_0000, 32'h7fff_ffff);
      issue_op(alu_ops[i], $urandom, $urandom);
      wait_done(200);
    end
    report_test("ALU operations", errs);
  endtask

  task automatic run_multiplies();
    logic [ROB_TAG_W-1:0] first_tag;
    int                   errs;
    errs      = fail_cnt;
    first_tag = next_tag;
    issue_op(OP_MUL, 32'hffff_ffff, 32'hffff_ffff);
    issue_op(OP_MULHU, 32'hffff_ffff, 32'hffff_ffff);
    repeat (2) begin
      issue_op(OP_MUL, $urandom, $urandom);
      issue_op(OP_MULHU, $urandom, $urandom);
    end
    wait_done(6 * 40);
    if (done_cycle[first_tag] - issue_cycle[first_tag] < 33) begin
      $display("[ERROR] %0t: first multiply completed %0d edges after issue", $time,
               done_cycle[first_tag] - issue_cycle[first_tag]);
      fail_cnt++;
    end else begin
      pass_cnt++;
    end
    report_test("multiplies", errs);
  endtask

  task automatic run_mixed_stream();
    logic [ROB_TAG_W-1:0] mul_tag;
    logic [ROB_TAG_W-1:0] tag;
    int                   errs;
    errs    = fail_cnt;
    mul_tag = next_tag;
    issue_op(OP_MUL, $urandom, $urandom);
    issue_op(OP_ADD, $urandom, $urandom);
    issue_op(OP_XOR, $urandom, $urandom);
    issue_op(OP_SLT, $urandom, $urandom);
    issue_op(OP_SRL, $urandom, $urandom);
    wait_done(5 * 40);
    for (int i = 1; i <= 4; i++) begin
      tag = mul_tag + ROB_TAG_W'(i);
      if (done_cycle[tag] >= done_cycle[mul_tag]) begin
        $display("[ERROR] %0t: ALU tag %0d finished after the multiply", $time, tag);
        fail_cnt++;
      end else begin
        pass_cnt++;
      end
    end
    report_test("mixed stream", errs);
  endtask

  task automatic run_backpressure();
    ixu_uop_t ops [13];
    int       sent;
    logic     saw_full;
    int       errs;
    errs     = fail_cnt;
    sent     = 0;
    saw_full = 1'b0;
    // ALU ops only, so the held completion has a single source
    for (int i = 0; i < 13; i++) begin
      make_uop(ixu_opcode_e'(i % 8), $urandom, $urandom, ops[i]);
    end
    @(negedge core_clock_i);
    complete_ready_i = 1'b0;
    repeat (60) begin
      issue_valid_i = sent < 13;
      if (sent < 13) begin
        issue_uop_i = ops[sent];
      end
      @(posedge core_clock_i);
      if (issue_valid_i && issue_ready_o) begin
        issue_cycle[ops[sent].rob_tag] = cycle_cnt;
        sent++;
      end
      if (!issue_ready_o) begin
        saw_full = 1'b1;
      end
      @(negedge core_clock_i);
    end
    issue_valid_i    = 1'b0;
    complete_ready_i = 1'b1;
    if (!saw_full) begin
      $display("The issue port never stalled while completion was blocked");
      fail_cnt++;
    end
    for (int i = sent; i < 13; i++) begin
      drive_uop(ops[i]);
    end
    wait_done(13 * 40);
    report_test("back-pressure", errs);
  endtask

  task automatic run_flush();
    int errs;
    errs = fail_cnt;
    @(negedge core_clock_i);
    complete_ready_i = 1'b0;
    issue_op(OP_MUL, $urandom, $urandom);
    issue_op(OP_AND, $urandom, $urandom);
    issue_op(OP_OR, $urandom, $urandom);
    issue_op(OP_SUB, $urandom, $urandom);
    repeat (3) @(negedge core_clock_i);
    core_flush_i = 1'b1;
    @(negedge core_clock_i);
    core_flush_i     = 1'b0;
    pending          = '0;
    complete_ready_i = 1'b1;
    if (issue_ready_o !== 1'b1 || complete_valid_o !== 1'b0) begin
      $display("[ERROR] %0t: issue_ready_o %b complete_valid_o %b after flush",
               $time, issue_ready_o, complete_valid_o);
      fail_cnt++;
    end else begin
      pass_cnt++;
    end
    // Long enough for a flushed multiply to have finished
    repeat (40) @(negedge core_clock_i);
    issue_op(OP_ADD, $urandom, $urandom);
    wait_done(100);
    report_test("flush", errs);
  endtask

  initial begin
    void'($urandom(34));
    reset_i          = 1'b1;
    core_flush_i     = 1'b0;
    issue_valid_i    = 1'b0;
    issue_uop_i      = '0;
    complete_ready_i = 1'b1;
    pending          = '0;
    next_tag         = '0;
    pass_cnt         = 0;
    fail_cnt         = 0;
    repeat (8) @(posedge core_clock_i);
    @(negedge core_clock_i);
    reset_i = 1'b0;
    check_reset_state();
    run_alu_ops();
    run_multiplies();
    run_mixed_stream();
    run_backpressure();
    run_flush();
    $display("Checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
